//--- filelist.f
+incdir+source
source/bus_pkg.sv
source/bus_arbiter.sv
source/addr_decoder.sv
source/bus_controller.sv
tb/tb_clock_gen.sv
tb/tb_bus_controller.sv

//--- source/addr_decoder.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module addr_decoder (
    input  bus_pkg::master_vec_t ack,
    input  bus_pkg::addr_t       virtual_addr,
    output bus_pkg::target_vec_t device_en,
    output bus_pkg::addr_t       phys_addr,
    output logic                 addr_error
);

    localparam int tgt_idx_w = $clog2(`BC_NUM_TARGETS);

    // Region map indexed by target id
    localparam bus_pkg::addr_t region_low [`BC_NUM_TARGETS] = '{
        `BC_RAM_ID: `BC_RAM_LOW,
        `BC_ROM_ID: `BC_ROM_LOW,
        `BC_VGA_ID: `BC_VGA_LOW,
        `BC_PS2_ID: `BC_PS2_LOW,
        `BC_ACP_ID: `BC_ACP_LOW
    };

    localparam bus_pkg::addr_t region_high [`BC_NUM_TARGETS] = '{
        `BC_RAM_ID: `BC_RAM_HIGH,
        `BC_ROM_ID: `BC_ROM_HIGH,
        `BC_VGA_ID: `BC_VGA_HIGH,
        `BC_PS2_ID: `BC_PS2_HIGH,
        `BC_ACP_ID: `BC_ACP_HIGH
    };

    // Search order for overlapping regions, first entry wins
    localparam int unsigned precedence [`BC_NUM_TARGETS] = '{
        `BC_ROM_ID,
        `BC_RAM_ID,
        `BC_VGA_ID,
        `BC_PS2_ID,
        `BC_ACP_ID
    };

    logic                 granted;
    bus_pkg::target_vec_t region_hit;
    logic                 region_any;
    logic [tgt_idx_w-1:0] sel_id;

    // Any ack bit means some requester drives the address
    assign granted = |ack;

    // Inclusive range compare, one per region
    for (genvar g = 0; g < `BC_NUM_TARGETS; g++) begin : g_region
        assign region_hit[g] = (virtual_addr >= region_low[g]) &&
                               (virtual_addr <= region_high[g]);
    end

    assign region_any = |region_hit;

    // Walk the precedence list backwards so the earliest listed hit is kept
    always_comb begin
        sel_id = '0;
        for (int k = `BC_NUM_TARGETS - 1; k >= 0; k--) begin
            if (region_hit[precedence[k]]) begin
                sel_id = tgt_idx_w'(precedence[k]);
            end
        end
    end

    // Outputs stay quiet unless the bus is granted
    // An unmapped address while granted raises addr_error and enables nothing
    always_comb begin
        device_en  = '0;
        phys_addr  = '0;
        addr_error = 1'b0;
        if (granted) begin
            if (region_any) begin
                device_en = bus_pkg::target_vec_t'(1) << sel_id;
                phys_addr = virtual_addr - region_low[sel_id];
            end else begin
                addr_error = 1'b1;
            end
        end
    end

    // A single target at most, and never one together with an address error
    a_decode_exclusive: assert final ($onehot0(device_en) &&
                                      !(addr_error && (device_en != '0)))
        else $error("addr_decoder: device_en 0x%0h with addr_error %0b",
                    device_en, addr_error);

endmodule

//--- source/bus_arbiter.sv
`timescale 1ns/1ps
`include "bus_config.svh"

module bus_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bus_pkg::master_vec_t req,
    output bus_pkg::master_vec_t ack
);

    bus_pkg::arb_state_e  state;
    bus_pkg::master_idx_t owner;
    bus_pkg::master_idx_t req_idx;
    logic                 req_any;

    // Fixed priority search, the lowest set request bit wins
    // Scanning from the top down lets the last hit be the lowest index
    always_comb begin
        req_any = |req;
        req_idx = '0;
        for (int i = `BC_NUM_MASTERS - 1; i >= 0; i--) begin
            if (req[i]) begin
                req_idx = bus_pkg::master_idx_t'(i);
            end
        end
    end

    // Grant FSM
    // A grant is issued on the edge that samples a request in ARB_IDLE, so ack
    // is high one cycle after req. The owner then holds the bus until its own
    // req is sampled low, whatever the other requesters do meanwhile
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= bus_pkg::ARB_IDLE;
            owner <= '0;
            ack   <= '0;
        end else begin
            case (state)
                bus_pkg::ARB_IDLE: begin
                    if (req_any) begin
                        owner <= req_idx;
                        ack   <= bus_pkg::master_vec_t'(1) << req_idx;
                        state <= bus_pkg::ARB_BUSY;
                    end
                end
                bus_pkg::ARB_BUSY: begin
                    // Release takes the bus back to idle for at least one cycle
                    if (!req[owner]) begin
                        ack   <= '0;
                        state <= bus_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    ack   <= '0;
                    state <= bus_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    // At most one requester owns the bus at any time
    property p_ack_onehot0;
        @(posedge clk) disable iff (!rst_n)
        $onehot0(ack);
    endproperty

    a_ack_onehot0: assert property (p_ack_onehot0)
        else $error("bus_arbiter: ack 0x%0h is not zero or one-hot", ack);

    // The latched owner and the ack register must agree while the bus is held
    property p_busy_owner_acked;
        @(posedge clk) disable iff (!rst_n)
        (state == bus_pkg::ARB_BUSY) |-> ack[owner];
    endproperty

    a_busy_owner_acked: assert property (p_busy_owner_acked)
        else $error("bus_arbiter: busy but ack bit %0d of owner is low", owner);

    // A newly raised ack bit must come from a request seen at the previous edge
    property p_ack_needs_req;
        @(posedge clk) disable iff (!rst_n)
        (ack & ~$past(ack) & ~$past(req)) == '0;
    endproperty

    a_ack_needs_req: assert property (p_ack_needs_req)
        else $error("bus_arbiter: ack 0x%0h rose without a sampled request", ack);

endmodule

//--- source/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// Requester side of the bus
`define BC_NUM_MASTERS   8
`define BC_MASTER_IDX_W  3

`define BC_ADDR_W        32

// Target side of the bus, one enable bit per region
`define BC_NUM_TARGETS   5

// RAM is 8M x 16 bits
`define BC_RAM_LOW       32'h0000_0000
`define BC_RAM_HIGH      32'h007F_FFFF
`define BC_RAM_ID        0

// ROM is 8M x 16 bits
`define BC_ROM_LOW       32'h0080_0000
`define BC_ROM_HIGH      32'h00FF_FFFF
`define BC_ROM_ID        1

// The three peripherals get 16 x 16 bits each
`define BC_VGA_LOW       32'h0100_0000
`define BC_VGA_HIGH      32'h0100_000F
`define BC_VGA_ID        2

`define BC_PS2_LOW       32'h0100_0010
`define BC_PS2_HIGH      32'h0100_001F
`define BC_PS2_ID        3

`define BC_ACP_LOW       32'h0100_0020
`define BC_ACP_HIGH      32'h0100_002F
`define BC_ACP_ID        4

`endif

//--- source/bus_controller.sv
`timescale 1ns/1ps

module bus_controller (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bus_pkg::master_vec_t req,
    input  bus_pkg::addr_t       virtual_addr,
    output bus_pkg::master_vec_t ack,
    output bus_pkg::target_vec_t device_en,
    output bus_pkg::addr_t       phys_addr,
    output logic                 addr_error
);

    // Registered grant, shared by the output port and the decoder
    bus_pkg::master_vec_t ack_int;

    assign ack = ack_int;

    // Picks the bus owner and holds it until the owner drops its request
    bus_arbiter u_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .ack   (ack_int)
    );

    // Maps the owner's address onto a target while the bus is granted
    // Its outputs follow ack in the same cycle
    addr_decoder u_decoder (
        .ack          (ack_int),
        .virtual_addr (virtual_addr),
        .device_en    (device_en),
        .phys_addr    (phys_addr),
        .addr_error   (addr_error)
    );

endmodule

//--- source/bus_pkg.sv
`include "bus_config.svh"

package bus_pkg;

    // One bit per requester, used for both req and ack
    typedef logic [`BC_NUM_MASTERS-1:0] master_vec_t;

    // Index of a single requester
    typedef logic [`BC_MASTER_IDX_W-1:0] master_idx_t;

    // Bus address, virtual on the input side and target relative on the output side
    typedef logic [`BC_ADDR_W-1:0] addr_t;

    // One-hot target enable, bit positions are the BC_*_ID values
    typedef logic [`BC_NUM_TARGETS-1:0] target_vec_t;

    // Arbiter states
    // ARB_IDLE means nobody owns the bus and a grant may be issued
    // ARB_BUSY means the latched owner keeps the bus until it drops req
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_e;

endpackage

//--- tb/bus_cases.txt
// Columns, all hex: req virtual_addr ack device_en phys_addr addr_error
// ack on a line comes from req of the line before it, sampled at the edge between them
// Reset cycles, nothing granted whatever the address
00 00000000 00 00 00000000 0
00 00000000 00 00 00000000 0
00 00001000 00 00 00000000 0
00 00001000 00 00 00000000 0
00 00001000 00 00 00000000 0
// Out of reset, no request, valid addresses give no enable
00 00000000 00 00 00000000 0
00 00001234 00 00 00000000 0
00 00800000 00 00 00000000 0
// Requesters 5, 2 and 6 together, requester 2 wins
64 00000000 00 00 00000000 0
64 00000000 04 01 00000000 0
64 007fffff 04 01 007fffff 0
// Requester 0 joins while 2 holds the bus, then all regions are walked
65 00123456 04 01 00123456 0
65 00800000 04 02 00000000 0
65 00ffffff 04 02 007fffff 0
65 00a5a5a0 04 02 0025a5a0 0
65 01000000 04 04 00000000 0
65 0100000f 04 04 0000000f 0
65 01000007 04 04 00000007 0
65 01000010 04 08 00000000 0
65 0100001f 04 08 0000000f 0
65 01000018 04 08 00000008 0
65 01000020 04 10 00000000 0
65 0100002f 04 10 0000000f 0
65 01000025 04 10 00000005 0
// Unmapped addresses while granted
65 01000030 04 00 00000000 1
65 ffffffff 04 00 00000000 1
65 7fffffff 04 00 00000000 1
// Requester 2 releases, one idle cycle, then requester 0
61 00000010 04 01 00000010 0
61 00000010 00 00 00000000 0
61 00000020 01 01 00000020 0
61 00800004 01 02 00000004 0
// Requester 0 releases, requester 5 follows after the idle cycle
60 01000011 01 08 00000001 0
60 01000011 00 00 00000000 0
60 01000011 20 08 00000001 0
40 01000028 20 10 00000008 0
// Requester 5 releases, requester 6 gets the bus on an unmapped address
40 01000028 00 00 00000000 0
40 01000030 40 00 00000000 1
00 01000030 40 00 00000000 1
00 01000030 00 00 00000000 0
00 00400000 00 00 00000000 0
// Highest index on its own
80 00400000 00 00 00000000 0
80 00400000 80 01 00400000 0
00 00ffffff 80 02 007fffff 0
00 00ffffff 00 00 00000000 0
// Single cycle request from requester 1
02 01000000 00 00 00000000 0
00 01000000 02 04 00000000 0
00 01000000 00 00 00000000 0

//--- tb/tb_bus_controller.sv
`timescale 1ns/1ps

module tb_bus_controller;

    localparam int    clk_period_ns  = 10;
    localparam int    reset_cycles   = 5;
    localparam int    drive_delay_ns = 1;
    localparam string case_file      = "tb/bus_cases.txt";

    logic                 clk;
    logic                 rst_n;
    bus_pkg::master_vec_t req;
    bus_pkg::addr_t       virtual_addr;
    bus_pkg::master_vec_t ack;
    bus_pkg::target_vec_t device_en;
    bus_pkg::addr_t       phys_addr;
    logic                 addr_error;

    // One entry per case line, stimulus first and expected outputs after it
    bus_pkg::master_vec_t case_req[$];
    bus_pkg::addr_t       case_addr[$];
    bus_pkg::master_vec_t case_ack[$];
    bus_pkg::target_vec_t case_en[$];
    bus_pkg::addr_t       case_phys[$];
    logic                 case_err[$];

    int  value_errors = 0;
    int  file_errors  = 0;
    int  timeouts     = 0;
    int  checks_run   = 0;
    int  cur_case     = 0;
    bit  cases_loaded = 1'b0;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    bus_controller u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .virtual_addr (virtual_addr),
        .ack          (ack),
        .device_en    (device_en),
        .phys_addr    (phys_addr),
        .addr_error   (addr_error)
    );

    task automatic check_master_vec(string name, bus_pkg::master_vec_t expected,
                                    bus_pkg::master_vec_t actual);
        checks_run++;
        if (actual !== expected) begin
            $display("** Error at time %0t: case %0d, %s expected 0x%0h, got 0x%0h",
                     $time, cur_case, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_target_vec(string name, bus_pkg::target_vec_t expected,
                                    bus_pkg::target_vec_t actual);
        checks_run++;
        if (actual !== expected) begin
            $display("** Error at time %0t: case %0d, %s expected 0x%0h, got 0x%0h",
                     $time, cur_case, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_addr(string name, bus_pkg::addr_t expected,
                              bus_pkg::addr_t actual);
        checks_run++;
        if (actual !== expected) begin
            $display("** Error at time %0t: case %0d, %s expected 0x%08h, got 0x%08h",
                     $time, cur_case, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        checks_run++;
        if (actual !== expected) begin
            $display("** Error at time %0t: case %0d, %s expected %b, got %b",
                     $time, cur_case, name, expected, actual);
            value_errors++;
        end
    endtask

    // Comment lines start with // and blank lines carry no case
    function automatic bit is_skippable(string line);
        int i;
        if (line.len() >= 2 && line.substr(0, 1) == "//") begin
            return 1'b1;
        end
        for (i = 0; i < line.len(); i++) begin
            if (line[i] != " " && line[i] != "\t" && line[i] != "\n" && line[i] != "\r") begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic load_cases();
        int                   fd;
        int                   line_no;
        int                   n;
        string                line;
        bus_pkg::master_vec_t f_req;
        bus_pkg::addr_t       f_addr;
        bus_pkg::master_vec_t f_ack;
        bus_pkg::target_vec_t f_en;
        bus_pkg::addr_t       f_phys;
        logic                 f_err;

        fd = $fopen(case_file, "r");
        if (fd == 0) begin
            $display("Could not open the case file %s", case_file);
            file_errors++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            line_no++;
            if (is_skippable(line)) begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h", f_req, f_addr, f_ack, f_en, f_phys, f_err);
            if (n != 6) begin
                $display("Line %0d of the case file %s is malformed, it has %0d of 6 fields",
                         line_no, case_file, (n < 0) ? 0 : n);
                file_errors++;
            end else begin
                case_req.push_back(f_req);
                case_addr.push_back(f_addr);
                case_ack.push_back(f_ack);
                case_en.push_back(f_en);
                case_phys.push_back(f_phys);
                case_err.push_back(f_err);
            end
        end
        $fclose(fd);
        if (case_req.size() == 0 && file_errors == 0) begin
            $display("The case file %s holds no cases", case_file);
            file_errors++;
        end
    endtask

    // Each case is driven just after a rising edge and its outputs are compared
    // one nanosecond before the next edge, when ack and the decoder have settled
    task automatic apply_cases();
        for (int k = 0; k < case_req.size(); k++) begin
            @(posedge clk);
            #(drive_delay_ns);
            req          = case_req[k];
            virtual_addr = case_addr[k];
            cur_case     = k;
            #(clk_period_ns - drive_delay_ns - 1);
            check_master_vec("ack", case_ack[k], ack);
            check_target_vec("device_en", case_en[k], device_en);
            check_addr("phys_addr", case_phys[k], phys_addr);
            check_bit("addr_error", case_err[k], addr_error);
        end
    endtask

    task automatic finish_run();
        $display("Checks run: %0d, value errors: %0d, case file errors: %0d, timeouts: %0d",
                 checks_run, value_errors, file_errors, timeouts);
        if (value_errors == 0 && file_errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    initial begin
        req          = '0;
        virtual_addr = '0;
        load_cases();
        cases_loaded = 1'b1;
        if (file_errors == 0) begin
            apply_cases();
        end
        finish_run();
    end

    // Allows the reset cycles, one cycle per case and some margin
    initial begin : watchdog
        longint timeout_ns;
        wait (cases_loaded);
        timeout_ns = (reset_cycles + case_req.size() + 20) * clk_period_ns;
        #(timeout_ns);
        timeouts++;
        $display("Timeout: the run did not finish within %0d ns", timeout_ns);
        finish_run();
    end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period_ns = 5;
    localparam int reset_cycles   = 5;

    // Free running clock, 10 ns period with the first rising edge at 5 ns
    initial begin
        clk = 1'b0;
        forever begin
            #(half_period_ns) clk = ~clk;
        end
    end

    // Reset is held over the first five rising edges and released just after
    // the last of them, in step with the other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule
